//--- Bender.yml
package:
  name: axi_upsizer

export_include_dirs:
  - .

sources:
  - files:
      - upsizer_pkg.sv
      - burst_plan_if.sv
      - burst_planner.sv
      - upsizer_write_path.sv
      - upsizer_read_path.sv
      - axi_upsizer_top.sv
  - target: test
    files:
      - tb_axi_upsizer.sv

//--- axi_upsizer_top.sv
`timescale 1ns/1ps

module axi_upsizer_top
  import upsizer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Narrow AW
  input  logic         aw_valid_i,
  output logic         aw_ready_o,
  input  id_t          aw_id_i,
  input  addr_t        aw_addr_i,
  input  len_t         aw_len_i,
  input  size_t        aw_size_i,
  input  burst_t       aw_burst_i,
  input  cache_t       aw_cache_i,
  // Narrow W
  input  logic         w_valid_i,
  output logic         w_ready_o,
  input  narrow_data_t w_data_i,
  input  narrow_strb_t w_strb_i,
  input  logic         w_last_i,
  // Narrow B
  output logic         b_valid_o,
  input  logic         b_ready_i,
  output id_t          b_id_o,
  output resp_t        b_resp_o,
  // Narrow AR
  input  logic         ar_valid_i,
  output logic         ar_ready_o,
  input  id_t          ar_id_i,
  input  addr_t        ar_addr_i,
  input  len_t         ar_len_i,
  input  size_t        ar_size_i,
  input  burst_t       ar_burst_i,
  input  cache_t       ar_cache_i,
  // Narrow R
  output logic         r_valid_o,
  input  logic         r_ready_i,
  output id_t          r_id_o,
  output narrow_data_t r_data_o,
  output resp_t        r_resp_o,
  output logic         r_last_o,
  // Wide AW
  output logic         mst_aw_valid_o,
  input  logic         mst_aw_ready_i,
  output id_t          mst_aw_id_o,
  output addr_t        mst_aw_addr_o,
  output len_t         mst_aw_len_o,
  output size_t        mst_aw_size_o,
  output burst_t       mst_aw_burst_o,
  output cache_t       mst_aw_cache_o,
  // Wide W
  output logic         mst_w_valid_o,
  input  logic         mst_w_ready_i,
  output wide_data_u   mst_w_data_o,
  output wide_strb_t   mst_w_strb_o,
  output logic         mst_w_last_o,
  // Wide B
  input  logic         mst_b_valid_i,
  output logic         mst_b_ready_o,
  input  id_t          mst_b_id_i,
  input  resp_t        mst_b_resp_i,
  // Wide AR
  output logic         mst_ar_valid_o,
  input  logic         mst_ar_ready_i,
  output id_t          mst_ar_id_o,
  output addr_t        mst_ar_addr_o,
  output len_t         mst_ar_len_o,
  output size_t        mst_ar_size_o,
  output burst_t       mst_ar_burst_o,
  output cache_t       mst_ar_cache_o,
  // Wide R
  input  logic         mst_r_valid_i,
  output logic         mst_r_ready_o,
  input  id_t          mst_r_id_i,
  input  wide_data_u   mst_r_data_i,
  input  resp_t        mst_r_resp_i,
  input  logic         mst_r_last_i
);

  // Wide last is rebuilt from the burst counter, so narrow w_last_i stays unread
  upsizer_write_path u_write_path (.*);

  upsizer_read_path u_read_path (.*);

  // Write responses need no conversion
  assign b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = b_ready_i;
  assign b_id_o = mst_b_id_i;
  assign b_resp_o = mst_b_resp_i;

endmodule

//--- burst_plan_if.sv
`timescale 1ns/1ps

interface burst_plan_if
  import upsizer_pkg::*;
();

  // Request from the channel path
  addr_t  req_addr;
  len_t   req_len;
  size_t  req_size;
  burst_t req_burst;
  cache_t req_cache;

  // Planned wide burst
  len_t   plan_len;
  size_t  plan_size;
  logic   plan_upsize;

  modport requester (
    output req_addr, req_len, req_size, req_burst, req_cache,
    input  plan_len, plan_size, plan_upsize
  );

  modport planner (
    input  req_addr, req_len, req_size, req_burst, req_cache,
    output plan_len, plan_size, plan_upsize
  );

endinterface

//--- burst_planner.sv
`timescale 1ns/1ps

`include "upsizer_settings.svh"

module burst_planner
  import upsizer_pkg::*;
(
  burst_plan_if.planner plan
);

  addr_t size_step;
  addr_t first_beat;
  addr_t last_beat;
  addr_t wide_start;
  addr_t wide_end;
  addr_t wide_span;
  logic  upsize;

  // Only modifiable INCR bursts with more than one beat get repacked
  assign upsize = (plan.req_burst == BURST_INCR) && plan.req_cache[1] &&
                  (plan.req_len != '0);

  // Last narrow beat starts from the size-aligned first beat
  assign size_step = addr_t'(1) << plan.req_size;
  assign first_beat = plan.req_addr & ~(size_step - 1'b1);
  assign last_beat = first_beat + (addr_t'(plan.req_len) << plan.req_size);

  // Both ends aligned to a full wide beat
  assign wide_start = plan.req_addr & ~addr_t'(`WIDE_STRB_W - 1);
  assign wide_end = last_beat & ~addr_t'(`WIDE_STRB_W - 1);
  assign wide_span = (wide_end - wide_start) >> `WIDE_MAX_SIZE;

  assign plan.plan_upsize = upsize;
  assign plan.plan_len = upsize ? len_t'(wide_span) : plan.req_len;
  assign plan.plan_size = upsize ? size_t'(`WIDE_MAX_SIZE) : plan.req_size;

endmodule

//--- filelist.f
+incdir+.
upsizer_pkg.sv
burst_plan_if.sv
burst_planner.sv
upsizer_write_path.sv
upsizer_read_path.sv
axi_upsizer_top.sv
tb_axi_upsizer.sv

//--- tb_axi_upsizer.sv
`timescale 1ns/1ps

`include "upsizer_settings.svh"

module tb_axi_upsizer
  import upsizer_pkg::*;
();

  localparam int NUM_ROWS = 12;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 200;
  localparam resp_t RESP_OKAY = 2'b00;

  typedef struct {
    string       name;
    id_t         id;
    addr_t       addr;
    len_t        len;
    size_t       size;
    burst_t      burst;
    cache_t      cache;
    len_t        exp_len;
    size_t       exp_size;
    logic [31:0] seed;
    bit          read_back;
    bit          stall;
  } row_t;

  logic clk_i, rst_ni;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  logic mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  id_t aw_id_i, b_id_o, ar_id_i, r_id_o, mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  addr_t aw_addr_i, ar_addr_i, mst_aw_addr_o, mst_ar_addr_o;
  len_t aw_len_i, ar_len_i, mst_aw_len_o, mst_ar_len_o;
  size_t aw_size_i, ar_size_i, mst_aw_size_o, mst_ar_size_o;
  burst_t aw_burst_i, ar_burst_i, mst_aw_burst_o, mst_ar_burst_o;
  cache_t aw_cache_i, ar_cache_i, mst_aw_cache_o, mst_ar_cache_o;
  resp_t b_resp_o, r_resp_o, mst_b_resp_i, mst_r_resp_i;
  narrow_data_t w_data_i, r_data_o;
  narrow_strb_t w_strb_i;
  wide_data_u mst_w_data_o, mst_r_data_i;
  wide_strb_t mst_w_strb_o;

  row_t rows [NUM_ROWS];
  logic [7:0] mem [0:255];
  logic [7:0] exp_mem [0:255];
  bit stall_en;

  // Wide memory model state
  addr_t wr_addr, rd_addr;
  size_t wr_size, rd_size, got_aw_size, got_ar_size;
  burst_t wr_burst, rd_burst;
  cache_t got_aw_cache, got_ar_cache;
  id_t wr_id, rd_id, b_id;
  int unsigned wr_beats;
  len_t rd_left, got_aw_len, got_w_len, got_ar_len;
  logic b_pending, rd_active;

  axi_upsizer_top uut (.*);

  always #20 clk_i = ~clk_i;

  task automatic fail_now();
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_len(string name, len_t exp, len_t act);
    if (exp !== act) begin
      $display("MISMATCH %s len: expected %0d, actual %0d", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_size(string name, size_t exp, size_t act);
    if (exp !== act) begin
      $display("MISMATCH %s size: expected %0d, actual %0d", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_data(string name, narrow_data_t exp, narrow_data_t act);
    if (exp !== act) begin
      $display("MISMATCH %s data: expected %08h, actual %08h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_resp(string name, resp_t exp, resp_t act);
    if (exp !== act) begin
      $display("MISMATCH %s resp: expected %0d, actual %0d", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_last(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("MISMATCH %s last: expected %0b, actual %0b", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_id(string name, id_t exp, id_t act);
    if (exp !== act) begin
      $display("MISMATCH %s id: expected %0h, actual %0h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_cache(string name, cache_t exp, cache_t act);
    if (exp !== act) begin
      $display("MISMATCH %s cache: expected %0h, actual %0h", name, exp, act);
      fail_now();
    end
  endtask

  // Narrow lanes from the address offset up to the end of the size-aligned beat
  function automatic narrow_strb_t narrow_lanes(addr_t a, size_t s);
    int unsigned first;
    int unsigned last;
    narrow_strb_t m;
    first = a % 4;
    last = (a - (a % (1 << s))) % 4 + (1 << s) - 1;
    for (int n = 0; n < `NARROW_STRB_W; n++) begin
      m[n] = (n >= first) && (n <= last);
    end
    return m;
  endfunction

  function automatic addr_t step_addr(addr_t a, size_t s, burst_t b);
    addr_t nbytes;
    nbytes = addr_t'(1) << s;
    if (b == BURST_FIXED) begin
      return a;
    end
    return a - (a % nbytes) + nbytes;
  endfunction

  function automatic narrow_data_t expected_word(addr_t a, size_t s);
    narrow_strb_t m;
    narrow_data_t w;
    m = narrow_lanes(a, s);
    w = '0;
    for (int n = 0; n < `NARROW_STRB_W; n++) begin
      if (m[n]) begin
        w[8*n +: 8] = exp_mem[8'((a & ~addr_t'(3)) + n)];
      end
    end
    return w;
  endfunction

  task automatic fill_table();
    // name, id, addr, len, size, burst, cache, wide len, wide size, seed, read back, stall
    rows[0] = '{"incr4_aligned", 1, 'h10, 3, 2, BURST_INCR, 2, 1, 3, 'h11, 0, 0};
    rows[1] = '{"incr3_offset4", 2, 'h24, 2, 2, BURST_INCR, 2, 1, 3, 'h22, 1, 0};
    rows[2] = '{"incr_nonmod", 3, 'h40, 3, 2, BURST_INCR, 0, 3, 2, 'h33, 1, 0};
    rows[3] = '{"fixed3", 4, 'h58, 2, 2, BURST_FIXED, 2, 2, 2, 'h44, 1, 0};
    rows[4] = '{"single_off0", 5, 'h68, 0, 2, BURST_INCR, 2, 0, 2, 'h55, 1, 0};
    rows[5] = '{"single_off1", 6, 'h6d, 0, 0, BURST_INCR, 2, 0, 0, 'h66, 1, 0};
    rows[6] = '{"single_off2", 7, 'h72, 0, 1, BURST_INCR, 2, 0, 1, 'h77, 1, 0};
    rows[7] = '{"single_off3", 8, 'h77, 0, 0, BURST_INCR, 2, 0, 0, 'h88, 1, 0};
    rows[8] = '{"incr8_stall", 9, 'h80, 7, 2, BURST_INCR, 2, 3, 3, 'h99, 1, 1};
    rows[9] = '{"incr5_stall", 10, 'ha4, 4, 2, BURST_INCR, 2, 2, 3, 'haa, 1, 1};
    rows[10] = '{"nonmod_stall", 11, 'hc0, 3, 2, BURST_INCR, 0, 3, 2, 'hbb, 1, 1};
    rows[11] = '{"incr_half_stall", 12, 'hd2, 5, 1, BURST_INCR, 2, 1, 3, 'hcc, 1, 1};
  endtask

  task automatic init_inputs();
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {aw_valid_i, aw_id_i, aw_addr_i, aw_len_i, aw_size_i, aw_burst_i, aw_cache_i} = '0;
    {w_valid_i, w_data_i, w_strb_i, w_last_i} = '0;
    {ar_valid_i, ar_id_i, ar_addr_i, ar_len_i, ar_size_i, ar_burst_i, ar_cache_i} = '0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b0;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i = 1'b1;
    mst_ar_ready_i = 1'b1;
    {mst_b_valid_i, mst_b_id_i, mst_b_resp_i} = '0;
    {mst_r_valid_i, mst_r_id_i, mst_r_data_i, mst_r_resp_i, mst_r_last_i} = '0;
    {b_pending, rd_active, stall_en, wr_addr, rd_addr, rd_left} = '0;
  endtask

  task automatic write_burst(row_t r);
    addr_t a;
    narrow_data_t data;
    narrow_strb_t lanes;
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    {aw_id_i, aw_addr_i, aw_len_i} = {r.id, r.addr, r.len};
    {aw_size_i, aw_burst_i, aw_cache_i} = {r.size, r.burst, r.cache};
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    a = r.addr;
    for (int i = 0; i <= int'(r.len); i++) begin
      data = $urandom() ^ r.seed;
      lanes = narrow_lanes(a, r.size);
      w_valid_i = 1'b1;
      w_data_i = data;
      w_strb_i = lanes;
      w_last_i = (i == int'(r.len));
      @(posedge clk_i);
      while (!w_ready_o) @(posedge clk_i);
      for (int n = 0; n < `NARROW_STRB_W; n++) begin
        if (lanes[n]) begin
          exp_mem[8'((a & ~addr_t'(3)) + n)] = data[8*n +: 8];
        end
      end
      a = step_addr(a, r.size, r.burst);
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    @(posedge clk_i);
    while (!(b_valid_o && b_ready_i)) @(posedge clk_i);
    check_id(r.name, r.id, b_id_o);
    check_resp(r.name, RESP_OKAY, b_resp_o);
    check_len(r.name, r.exp_len, got_aw_len);
    check_size(r.name, r.exp_size, got_aw_size);
    check_cache(r.name, r.cache, got_aw_cache);
    // Number of wide W beats up to last
    check_len(r.name, r.exp_len, got_w_len);
  endtask

  task automatic read_burst(row_t r);
    addr_t a;
    int beat;
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    {ar_id_i, ar_addr_i, ar_len_i} = {r.id, r.addr, r.len};
    {ar_size_i, ar_burst_i, ar_cache_i} = {r.size, r.burst, r.cache};
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    a = r.addr;
    beat = 0;
    while (beat <= int'(r.len)) begin
      r_ready_i = r.stall ? 1'($urandom_range(1, 0)) : 1'b1;
      @(posedge clk_i);
      if (r_valid_o && r_ready_i) begin
        check_data(r.name, expected_word(a, r.size), r_data_o);
        check_resp(r.name, RESP_OKAY, r_resp_o);
        check_last(r.name, beat == int'(r.len), r_last_o);
        check_id(r.name, r.id, r_id_o);
        a = step_addr(a, r.size, r.burst);
        beat++;
      end
      @(negedge clk_i);
    end
    r_ready_i = 1'b0;
    check_len(r.name, r.exp_len, got_ar_len);
    check_size(r.name, r.exp_size, got_ar_size);
    check_cache(r.name, r.cache, got_ar_cache);
  endtask

  task automatic compare_memory(string name);
    narrow_data_t exp_word;
    narrow_data_t act_word;
    for (int w = 0; w < 64; w++) begin
      for (int n = 0; n < `NARROW_STRB_W; n++) begin
        exp_word[8*n +: 8] = exp_mem[4*w + n];
        act_word[8*n +: 8] = mem[4*w + n];
      end
      check_data({name, " memory"}, exp_word, act_word);
    end
  endtask

  // Model samples wide handshakes on the rising edge
  always @(posedge clk_i) begin
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      {wr_addr, wr_size, wr_burst, wr_id} = {mst_aw_addr_o, mst_aw_size_o, mst_aw_burst_o,
                                             mst_aw_id_o};
      {got_aw_len, got_aw_size} = {mst_aw_len_o, mst_aw_size_o};
      got_aw_cache = mst_aw_cache_o;
      wr_beats = 0;
    end
    if (mst_w_valid_o && mst_w_ready_i) begin
      for (int k = 0; k < `WIDE_STRB_W; k++) begin
        if (mst_w_strb_o[k]) begin
          mem[8'((wr_addr & ~addr_t'(7)) + k)] = mst_w_data_o.lanes[k];
        end
      end
      if (mst_w_last_o) begin
        got_w_len = len_t'(wr_beats);
        b_pending = 1'b1;
        b_id = wr_id;
      end
      wr_beats++;
      wr_addr = step_addr(wr_addr, wr_size, wr_burst);
    end
    if (mst_b_valid_i && mst_b_ready_o) begin
      b_pending = 1'b0;
    end
    if (mst_ar_valid_o && mst_ar_ready_i) begin
      {rd_addr, rd_size, rd_burst, rd_id} = {mst_ar_addr_o, mst_ar_size_o, mst_ar_burst_o,
                                             mst_ar_id_o};
      {got_ar_len, got_ar_size, rd_left} = {mst_ar_len_o, mst_ar_size_o, mst_ar_len_o};
      got_ar_cache = mst_ar_cache_o;
      rd_active = 1'b1;
    end else if (mst_r_valid_i && mst_r_ready_o) begin
      rd_active = (rd_left != '0);
      rd_left = rd_left - 1'b1;
      rd_addr = step_addr(rd_addr, rd_size, rd_burst);
    end
  end

  // Model drives its outputs on the falling edge
  always @(negedge clk_i) begin
    mst_w_ready_i = stall_en ? 1'($urandom_range(1, 0)) : 1'b1;
    {mst_b_valid_i, mst_b_id_i, mst_b_resp_i} = {b_pending, b_id, RESP_OKAY};
    {mst_r_valid_i, mst_r_id_i, mst_r_resp_i} = {rd_active, rd_id, RESP_OKAY};
    mst_r_last_i = rd_active && (rd_left == '0);
    for (int k = 0; k < `WIDE_STRB_W; k++) begin
      mst_r_data_i.lanes[k] = mem[8'((rd_addr & ~addr_t'(7)) + k)];
    end
  end

  initial begin
    void'($urandom(32'hfdb2068e));
    fill_table();
    init_inputs();
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'(a) ^ 8'ha5;
      exp_mem[a] = 8'(a) ^ 8'ha5;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      stall_en = rows[i].stall;
      write_burst(rows[i]);
      compare_memory(rows[i].name);
      if (rows[i].read_back) begin
        read_burst(rows[i]);
      end
    end
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the test table did not finish within %0d cycles", WATCHDOG_CYCLES);
    fail_now();
  end

endmodule

//--- upsizer_pkg.sv
`include "upsizer_settings.svh"

package upsizer_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`ID_W-1:0] id_t;
  typedef logic [`LEN_W-1:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [3:0] cache_t;
  typedef logic [1:0] resp_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR = 2'b01;

  typedef logic [`NARROW_DATA_W-1:0] narrow_data_t;
  typedef logic [`NARROW_STRB_W-1:0] narrow_strb_t;
  typedef logic [`WIDE_STRB_W-1:0] wide_strb_t;

  // One wide beat, seen as byte lanes or as narrow words
  typedef union packed {
    logic [`WIDE_STRB_W-1:0][7:0] lanes;
    narrow_data_t [`WIDE_DATA_W/`NARROW_DATA_W-1:0] words;
  } wide_data_u;

  typedef enum logic [1:0] {
    IDLE,
    PASSTHROUGH,
    INCR_UPSIZE
  } path_state_e;

  // Narrow lanes that carry bytes of the beat at addr
  function automatic narrow_strb_t lane_mask(addr_t addr, size_t size);
    narrow_strb_t mask;
    int unsigned nbytes;
    int unsigned offset;
    int unsigned base;
    nbytes = 1 << size;
    offset = addr % `NARROW_STRB_W;
    base = offset & ~(nbytes - 1);
    for (int n = 0; n < `NARROW_STRB_W; n++) begin
      mask[n] = (n >= offset) && (n < base + nbytes);
    end
    return mask;
  endfunction

  // Address of the following beat
  function automatic addr_t next_beat_addr(addr_t addr, size_t size, burst_t burst);
    addr_t step;
    step = addr_t'(1) << size;
    if (burst == BURST_FIXED) begin
      return addr;
    end
    return (addr & ~(step - 1'b1)) + step;
  endfunction

endpackage

//--- upsizer_read_path.sv
`timescale 1ns/1ps

`include "upsizer_settings.svh"

module upsizer_read_path
  import upsizer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Narrow side
  input  logic         ar_valid_i,
  output logic         ar_ready_o,
  input  id_t          ar_id_i,
  input  addr_t        ar_addr_i,
  input  len_t         ar_len_i,
  input  size_t        ar_size_i,
  input  burst_t       ar_burst_i,
  input  cache_t       ar_cache_i,
  output logic         r_valid_o,
  input  logic         r_ready_i,
  output id_t          r_id_o,
  output narrow_data_t r_data_o,
  output resp_t        r_resp_o,
  output logic         r_last_o,
  // Wide side
  output logic         mst_ar_valid_o,
  input  logic         mst_ar_ready_i,
  output id_t          mst_ar_id_o,
  output addr_t        mst_ar_addr_o,
  output len_t         mst_ar_len_o,
  output size_t        mst_ar_size_o,
  output burst_t       mst_ar_burst_o,
  output cache_t       mst_ar_cache_o,
  input  logic         mst_r_valid_i,
  output logic         mst_r_ready_o,
  input  id_t          mst_r_id_i,
  input  wide_data_u   mst_r_data_i,
  input  resp_t        mst_r_resp_i,
  input  logic         mst_r_last_i
);

  path_state_e  state_q;
  logic         ar_valid_q;

  id_t          id_q;
  addr_t        addr_q;
  len_t         len_q;
  size_t        size_q;
  burst_t       burst_q;
  cache_t       cache_q;
  size_t        beat_size_q;
  addr_t        cur_addr_q;
  len_t         cnt_q;

  narrow_strb_t lane_en;
  addr_t        next_addr;
  logic         ar_fire;
  logic         r_fire;
  logic         release_beat;

  burst_plan_if plan_if ();

  assign plan_if.req_addr = ar_addr_i;
  assign plan_if.req_len = ar_len_i;
  assign plan_if.req_size = ar_size_i;
  assign plan_if.req_burst = ar_burst_i;
  assign plan_if.req_cache = ar_cache_i;

  burst_planner u_planner (
    .plan (plan_if)
  );

  assign ar_ready_o = (state_q == IDLE);
  assign ar_fire = ar_valid_i && ar_ready_o;

  // Response beats count only once the wide AR has gone out
  assign r_valid_o = (state_q != IDLE) && !ar_valid_q && mst_r_valid_i;
  assign r_fire = r_valid_o && r_ready_i;
  assign r_id_o = mst_r_id_i;
  assign r_resp_o = mst_r_resp_i;
  assign r_last_o = mst_r_last_i && (cnt_q == '0);

  assign lane_en = lane_mask(cur_addr_q, beat_size_q);
  assign next_addr = next_beat_addr(cur_addr_q, beat_size_q, burst_q);

  // In upsize mode a wide beat is kept until its last narrow word is read
  assign release_beat = (state_q == PASSTHROUGH) || (cnt_q == '0) ||
                        (next_addr[`ADDR_W-1:`WIDE_MAX_SIZE] !=
                         cur_addr_q[`ADDR_W-1:`WIDE_MAX_SIZE]);
  assign mst_r_ready_o = r_fire && release_beat;

  always_comb begin
    narrow_data_t word;
    // Address bit 2 picks the narrow word, lanes keep their byte offset
    word = mst_r_data_i.words[cur_addr_q[2]];
    for (int n = 0; n < `NARROW_STRB_W; n++) begin
      r_data_o[8*n +: 8] = lane_en[n] ? word[8*n +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ar_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        state_q <= plan_if.plan_upsize ? INCR_UPSIZE : PASSTHROUGH;
      end else if (r_fire && (cnt_q == '0)) begin
        state_q <= IDLE;
      end
      if (ar_fire) begin
        ar_valid_q <= 1'b1;
      end else if (mst_ar_valid_o && mst_ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_q <= ar_id_i;
      addr_q <= ar_addr_i;
      len_q <= plan_if.plan_len;
      size_q <= plan_if.plan_size;
      burst_q <= ar_burst_i;
      cache_q <= ar_cache_i;
      beat_size_q <= ar_size_i;
      cur_addr_q <= ar_addr_i;
      cnt_q <= ar_len_i;
    end else if (r_fire) begin
      cur_addr_q <= next_addr;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign mst_ar_valid_o = ar_valid_q;
  assign mst_ar_id_o = id_q;
  assign mst_ar_addr_o = addr_q;
  assign mst_ar_len_o = len_q;
  assign mst_ar_size_o = size_q;
  assign mst_ar_burst_o = burst_q;
  assign mst_ar_cache_o = cache_q;

endmodule

//--- upsizer_settings.svh
`ifndef UPSIZER_SETTINGS_SVH
`define UPSIZER_SETTINGS_SVH

// Data widths of the two ports
`define NARROW_DATA_W 32
`define WIDE_DATA_W 64

// Byte lanes per beat
`define NARROW_STRB_W 4
`define WIDE_STRB_W 8

// Size code of a full wide beat, log2 of the wide byte count
`define WIDE_MAX_SIZE 3

// Address and ID widths
`define ADDR_W 32
`define ID_W 4

// AXI burst length field
`define LEN_W 8

`endif

//--- upsizer_write_path.sv
`timescale 1ns/1ps

`include "upsizer_settings.svh"

module upsizer_write_path
  import upsizer_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Narrow side
  input  logic         aw_valid_i,
  output logic         aw_ready_o,
  input  id_t          aw_id_i,
  input  addr_t        aw_addr_i,
  input  len_t         aw_len_i,
  input  size_t        aw_size_i,
  input  burst_t       aw_burst_i,
  input  cache_t       aw_cache_i,
  input  logic         w_valid_i,
  output logic         w_ready_o,
  input  narrow_data_t w_data_i,
  input  narrow_strb_t w_strb_i,
  // Wide side
  output logic         mst_aw_valid_o,
  input  logic         mst_aw_ready_i,
  output id_t          mst_aw_id_o,
  output addr_t        mst_aw_addr_o,
  output len_t         mst_aw_len_o,
  output size_t        mst_aw_size_o,
  output burst_t       mst_aw_burst_o,
  output cache_t       mst_aw_cache_o,
  output logic         mst_w_valid_o,
  input  logic         mst_w_ready_i,
  output wide_data_u   mst_w_data_o,
  output wide_strb_t   mst_w_strb_o,
  output logic         mst_w_last_o
);

  path_state_e state_q;
  logic        aw_valid_q;
  logic        w_valid_q;
  logic        done_q;

  id_t         id_q;
  addr_t       addr_q;
  len_t        len_q;
  size_t       size_q;
  burst_t      burst_q;
  cache_t      cache_q;
  size_t       beat_size_q;
  addr_t       cur_addr_q;
  len_t        cnt_q;
  wide_data_u  w_data_q;
  wide_strb_t  w_strb_q;
  logic        w_last_q;

  wide_data_u  w_data_next;
  wide_strb_t  w_strb_next;
  addr_t       next_addr;
  logic        aw_fire;
  logic        w_fire;
  logic        w_take;
  logic        send_beat;

  burst_plan_if plan_if ();

  assign plan_if.req_addr = aw_addr_i;
  assign plan_if.req_len = aw_len_i;
  assign plan_if.req_size = aw_size_i;
  assign plan_if.req_burst = aw_burst_i;
  assign plan_if.req_cache = aw_cache_i;

  burst_planner u_planner (
    .plan (plan_if)
  );

  assign aw_ready_o = (state_q == IDLE);
  assign aw_fire = aw_valid_i && aw_ready_o;
  assign w_take = mst_w_valid_o && mst_w_ready_i;

  // Narrow data only flows once the wide AW is out and the held beat can move
  assign w_ready_o = (state_q != IDLE) && !aw_valid_q && !done_q &&
                     (!w_valid_q || mst_w_ready_i);
  assign w_fire = w_valid_i && w_ready_o;

  assign next_addr = next_beat_addr(cur_addr_q, beat_size_q, burst_q);

  // Send on every beat in passthrough, else on a full wide word or the burst end
  assign send_beat = (state_q == PASSTHROUGH) || (cnt_q == '0) ||
                     (next_addr[`ADDR_W-1:`WIDE_MAX_SIZE] !=
                      cur_addr_q[`ADDR_W-1:`WIDE_MAX_SIZE]);

  always_comb begin
    narrow_strb_t lane_en;
    lane_en = lane_mask(cur_addr_q, beat_size_q);
    w_data_next = w_data_q;
    // A held beat leaving this cycle starts a fresh wide word
    w_strb_next = w_valid_q ? '0 : w_strb_q;
    for (int n = 0; n < `NARROW_STRB_W; n++) begin
      if (lane_en[n]) begin
        // Address bit 2 picks the narrow word inside the wide beat
        w_data_next.lanes[`NARROW_STRB_W * cur_addr_q[2] + n] = w_data_i[8*n +: 8];
        w_strb_next[`NARROW_STRB_W * cur_addr_q[2] + n] = w_strb_i[n];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (aw_fire) begin
        state_q <= plan_if.plan_upsize ? INCR_UPSIZE : PASSTHROUGH;
      end else if (w_take && w_last_q) begin
        state_q <= IDLE;
      end
      if (aw_fire) begin
        aw_valid_q <= 1'b1;
      end else if (mst_aw_valid_o && mst_aw_ready_i) begin
        aw_valid_q <= 1'b0;
      end
      if (w_fire && send_beat) begin
        w_valid_q <= 1'b1;
      end else if (w_take) begin
        w_valid_q <= 1'b0;
      end
      if (aw_fire) begin
        done_q <= 1'b0;
      end else if (w_fire && (cnt_q == '0)) begin
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_q <= aw_id_i;
      addr_q <= aw_addr_i;
      len_q <= plan_if.plan_len;
      size_q <= plan_if.plan_size;
      burst_q <= aw_burst_i;
      cache_q <= aw_cache_i;
      beat_size_q <= aw_size_i;
      cur_addr_q <= aw_addr_i;
      cnt_q <= aw_len_i;
      w_strb_q <= '0;
    end
    if (w_fire) begin
      w_data_q <= w_data_next;
      w_strb_q <= w_strb_next;
      w_last_q <= (cnt_q == '0);
      cur_addr_q <= next_addr;
      cnt_q <= cnt_q - 1'b1;
    end else if (w_take) begin
      w_strb_q <= '0;
    end
  end

  assign mst_aw_valid_o = aw_valid_q;
  assign mst_aw_id_o = id_q;
  assign mst_aw_addr_o = addr_q;
  assign mst_aw_len_o = len_q;
  assign mst_aw_size_o = size_q;
  assign mst_aw_burst_o = burst_q;
  assign mst_aw_cache_o = cache_q;
  assign mst_w_valid_o = w_valid_q;
  assign mst_w_data_o = w_data_q;
  assign mst_w_strb_o = w_strb_q;
  assign mst_w_last_o = w_last_q;

endmodule
